/* branchUnit.f */
+incdir+hdl
hdl/branchPkg.sv
hdl/regFile.sv
hdl/branchCond.sv
hdl/pcSelect.sv
hdl/branchCtrl.sv
hdl/branchUnit.sv
verif/branchUnit_asserts.sv
verif/branchUnit_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := branchUnit_tb
FILELIST := branchUnit.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* verif/branchUnit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branchUnit_tb
    import branchPkg::*;
();

    localparam int NumRequests = 300;
    localparam int MaxCycles   = 16 + NumRequests * 12;

    logic       clk;
    logic       rstN;
    logic       req;
    branchReqT  reqData;
    logic       ack;
    branchRespT resp;
    regWriteT   regWr;

    wordT        shadow [`REG_COUNT];
    branchRespT  expQ [$];
    logic [31:0] rngState = 32'd45;
    logic        ackSeen = 1'b0;
    int          cycleCount = 0;

    branchUnit uut (
        .clk(clk), .rstN(rstN), .req(req), .reqData(reqData),
        .ack(ack), .resp(resp), .regWr(regWr)
    );

    bind branchCtrl branchUnit_asserts handshakeChecks (
        .clk(clk), .rstN(rstN), .req(req), .ack(ack), .resp(resp), .state(state)
    );

    always #4 clk = ~clk;

    function automatic wordT nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // sign boundaries show up often
    function automatic wordT pickValue();
        wordT rnd;
        rnd = nextRand();
        case (rnd[2:0])
            3'd0: return '0;
            3'd1: return 32'd1;
            3'd2: return '1;
            3'd3: return 32'h8000_0000;
            3'd4: return 32'h7FFF_FFFF;
            default: return nextRand();
        endcase
    endfunction

    function automatic branchRespT expectedResp(branchReqT r, wordT regs [`REG_COUNT]);
        wordT       a;
        wordT       b;
        wordT       target;
        branchRespT e;
        a = regs[r.rs1Addr];
        b = regs[r.rs2Addr];
        e = '0;
        case (r.func3)
            BEQ:  e.taken = (a == b);
            BNE:  e.taken = (a != b);
            BLT:  e.taken = ($signed(a) < $signed(b));
            BGE:  e.taken = ($signed(a) >= $signed(b));
            BLTU: e.taken = (a < b);
            BGEU: e.taken = (a >= b);
            default: e.illegal = 1'b1;
        endcase
        target       = r.pc + r.imm;
        e.nextPc     = e.taken ? target : r.pc + 32'd4;
        e.misaligned = e.taken && (target[1:0] != 2'b00);
        return e;
    endfunction

    task automatic abortRun();
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkResp(branchRespT expected, branchRespT actual);
        if (actual !== expected) begin
            $write("[FAIL] t=%0t resp expected taken=%b illegal=%b misaligned=%b nextPc=%h,",
                   $time, expected.taken, expected.illegal, expected.misaligned,
                   expected.nextPc);
            $display(" actual taken=%b illegal=%b misaligned=%b nextPc=%h",
                     actual.taken, actual.illegal, actual.misaligned, actual.nextPc);
            abortRun();
        end
    endtask

    task automatic checkAck(logic expected, logic actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t ack expected %b actual %b", $time, expected, actual);
            abortRun();
        end
    endtask

    task automatic writeReg(regAddrT addr, wordT data);
        regWr = '{en: 1'b1, addr: addr, data: data};
        if (addr != '0) begin
            shadow[addr] = data;
        end
        @(negedge clk);
        regWr.en = 1'b0;
    endtask

    // one full four-phase transfer, req held for holdExtra cycles after ack
    task automatic runBranch(branchReqT r, int holdExtra);
        branchRespT expected;
        expected = expectedResp(r, shadow);
        expQ.push_back(expected);
        reqData = r;
        req     = 1'b1;
        repeat (2) begin
            @(negedge clk);
            checkAck(1'b0, ack);
        end
        @(negedge clk);
        checkAck(1'b1, ack);
        repeat (holdExtra) begin
            @(negedge clk);
            checkAck(1'b1, ack);
            checkResp(expected, resp);
        end
        req = 1'b0;
        @(negedge clk);
        checkAck(1'b0, ack);
    endtask

    // compare on each rising ack
    always @(negedge clk) begin
        if (rstN && ack && !ackSeen) begin
            if (expQ.size() == 0) begin
                $display("ack rose with no request outstanding at t=%0t", $time);
                abortRun();
            end else begin
                checkResp(expQ.pop_front(), resp);
            end
        end
        ackSeen = ack;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("timeout: the run did not end within %0d cycles", MaxCycles);
            abortRun();
        end
    end

    initial begin
        branchReqT r;
        wordT      rnd;
        int        holdExtra;
        clk     = 1'b0;
        rstN    = 1'b0;
        req     = 1'b0;
        reqData = '0;
        regWr   = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkAck(1'b0, ack);
        checkResp('0, resp);

        for (int i = 1; i < `REG_COUNT; i++) begin
            writeReg(regAddrT'(i), pickValue());
        end
        // x0 keeps reading zero, x1 holds zero to compare against
        writeReg('0, 32'hDEAD_BEEF);
        writeReg(5'd1, '0);
        r = '{pc: 32'h100, func3: BEQ, rs1Addr: '0, rs2Addr: 5'd1, imm: 32'd8};
        runBranch(r, 0);
        r = '{pc: 32'h200, func3: 3'b010, rs1Addr: 5'd1, rs2Addr: 5'd1, imm: 32'd6};
        runBranch(r, 1);
        r = '{pc: 32'h300, func3: 3'b011, rs1Addr: 5'd2, rs2Addr: 5'd3, imm: 32'd6};
        runBranch(r, 0);

        for (int n = 0; n < NumRequests; n++) begin
            rnd = nextRand();
            if (rnd[0] == 1'b0) begin
                writeReg(rnd[5:1], pickValue());
            end
            r.pc      = {rnd[31:8], rnd[7:6], 6'b000000};
            rnd       = nextRand();
            r.func3   = rnd[2:0];
            r.rs1Addr = rnd[7:3];
            // equal register pairs now and then
            r.rs2Addr = (rnd[9:8] == 2'b00) ? rnd[7:3] : rnd[14:10];
            r.imm     = {{19{rnd[27]}}, rnd[27:15]};
            if (rnd[28]) begin
                r.imm[1:0] = 2'b00;
            end
            holdExtra = int'(rnd[31:29]) % 6;
            runBranch(r, holdExtra);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/branchUnit_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module branchUnit_asserts
    import branchPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       req,
    input  logic       ack,
    input  branchRespT resp,
    input  ctrlStateE  state
);

    // ack only answers an open request, req seen at the edge that set ack
    assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // capture sampled three edges back, since ack is set by the second edge after it
    assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) == $past((state == IDLE) && req, 3))
        else $error("ack did not rise two cycles after the capture edge");

    assert property (@(posedge clk) disable iff (!rstN) (ack && $past(ack)) |-> $stable(resp))
        else $error("resp changed while ack was high");

    assert property (@(posedge clk) disable iff (!rstN) (ack && !req) |=> !ack)
        else $error("ack did not fall one edge after req was sampled low");

endmodule

`default_nettype wire

/* hdl/branchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branchUnit
    import branchPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       req,
    input  branchReqT  reqData,
    output logic       ack,
    output branchRespT resp,
    input  regWriteT   regWr
);

    regAddrT          rs1Addr;
    regAddrT          rs2Addr;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;

    branchOpE         func3;
    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;

    logic             taken;
    logic             illegal;
    logic [`XLEN-1:0] nextPc;
    logic             misaligned;

    branchCtrl u_ctrl (
        .clk(clk), .rstN(rstN), .req(req), .reqData(reqData), .ack(ack), .resp(resp),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .func3(func3), .rs1(rs1), .rs2(rs2), .pc(pc), .imm(imm),
        .taken(taken), .illegal(illegal), .nextPc(nextPc), .misaligned(misaligned)
    );

    regFile u_regs (
        .clk(clk), .regWr(regWr), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    branchCond u_cond (
        .func3(func3), .rs1(rs1), .rs2(rs2), .taken(taken), .illegal(illegal)
    );

    pcSelect u_pcSel (
        .pc(pc), .imm(imm), .taken(taken), .nextPc(nextPc), .misaligned(misaligned)
    );

endmodule

`default_nettype wire

/* hdl/branchCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branchCtrl
    import branchPkg::*;
(
    input  logic             clk,
    input  logic             rstN,

    input  logic             req,
    input  branchReqT        reqData,
    output logic             ack,
    output branchRespT       resp,

    output regAddrT          rs1Addr,
    output regAddrT          rs2Addr,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,

    output branchOpE         func3,
    output logic [`XLEN-1:0] rs1,
    output logic [`XLEN-1:0] rs2,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] imm,

    input  logic             taken,
    input  logic             illegal,
    input  logic [`XLEN-1:0] nextPc,
    input  logic             misaligned
);

    ctrlStateE        state;
    branchReqT        reqQ;
    logic [`XLEN-1:0] rs1Q;
    logic [`XLEN-1:0] rs2Q;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            resp  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= READ;
                    end
                end
                READ: begin
                    state <= RESP;
                end
                RESP: begin
                    resp  <= '{taken: taken, illegal: illegal,
                               misaligned: misaligned, nextPc: nextPc};
                    state <= DONE;
                end
                DONE: begin
                    // hold until the requester lets go
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request and operand capture
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req) begin
            reqQ <= reqData;
        end
        if (state == READ) begin
            rs1Q <= rs1Data;
            rs2Q <= rs2Data;
        end
    end

    assign ack = (state == DONE);

    assign rs1Addr = reqQ.rs1Addr;
    assign rs2Addr = reqQ.rs2Addr;
    assign func3   = branchOpE'(reqQ.func3);
    assign rs1     = rs1Q;
    assign rs2     = rs2Q;
    assign pc      = reqQ.pc;
    assign imm     = reqQ.imm;

endmodule

`default_nettype wire

/* hdl/pcSelect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module pcSelect
    import branchPkg::*;
(
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] imm,
    input  logic             taken,
    output logic [`XLEN-1:0] nextPc,
    output logic             misaligned
);

    wordT target;
    wordT fallThrough;

    // both sums wrap at XLEN bits
    assign target      = pc + imm;
    assign fallThrough = pc + wordT'(4);

    assign nextPc     = taken ? target : fallThrough;
    assign misaligned = taken && (target[1:0] != 2'b00);

endmodule

`default_nettype wire

/* hdl/branchCond.sv */
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branchCond
    import branchPkg::*;
(
    input  branchOpE         func3,
    input  logic [`XLEN-1:0] rs1,
    input  logic [`XLEN-1:0] rs2,
    output logic             taken,
    output logic             illegal
);

    logic isEq;
    logic ltSigned;
    logic ltUnsigned;

    assign isEq       = (rs1 == rs2);
    assign ltSigned   = ($signed(rs1) < $signed(rs2));
    // raw bit patterns, no magnitude conversion
    assign ltUnsigned = (rs1 < rs2);

    always_comb begin
        taken   = 1'b0;
        illegal = 1'b0;
        case (func3)
            BEQ:  taken = isEq;
            BNE:  taken = !isEq;
            BLT:  taken = ltSigned;
            BGE:  taken = !ltSigned;
            BLTU: taken = ltUnsigned;
            BGEU: taken = !ltUnsigned;
            default: begin
                // 010 and 011 are not branches
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module regFile
    import branchPkg::*;
(
    input  logic             clk,
    input  regWriteT         regWr,
    input  regAddrT          rs1Addr,
    input  regAddrT          rs2Addr,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [`REG_COUNT-1:1];

    always_ff @(posedge clk) begin
        if (regWr.en && (regWr.addr != '0)) begin
            regs[regWr.addr] <= regWr.data;
        end
    end

    always_comb begin
        rs1Data = '0;
        if (rs1Addr != '0) begin
            rs1Data = regs[rs1Addr];
        end
    end

    always_comb begin
        rs2Data = '0;
        if (rs2Addr != '0) begin
            rs2Data = regs[rs2Addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/branchPkg.sv */
`default_nettype none

`include "branch_cfg.svh"

package branchPkg;

    typedef logic [`XLEN-1:0] wordT;
    typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;

    // func3 encodings of the conditional branches
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branchOpE;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        READ = 2'd1,
        RESP = 2'd2,
        DONE = 2'd3
    } ctrlStateE;

    typedef struct packed {
        wordT       pc;
        logic [2:0] func3;
        regAddrT    rs1Addr;
        regAddrT    rs2Addr;
        wordT       imm;
    } branchReqT;

    typedef struct packed {
        logic taken;
        logic illegal;
        logic misaligned;
        wordT nextPc;
    } branchRespT;

    typedef struct packed {
        logic    en;
        regAddrT addr;
        wordT    data;
    } regWriteT;

endpackage

`default_nettype wire

/* hdl/branch_cfg.svh */
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// architectural data and address width
`define XLEN 32

// number of integer registers, x0 included
`define REG_COUNT 32

`endif
